// ==== hdl/dotEngine_defs.svh ====
`ifndef DOTENGINE_DEFS_SVH
`define DOTENGINE_DEFS_SVH

//////////////////////////////////////////////////
// Vector geometry
//////////////////////////////////////////////////

// Products per pass
`define VEC_LEN 28

// Memory depths
`define W_DEPTH 32
`define P_DEPTH 256

//////////////////////////////////////////////////
// Data widths
//////////////////////////////////////////////////

`define PIX_W 8
`define WGT_W 8

// Holds 28 x 255 x 128 with sign
`define SUM_W 24

// Pass counter, up to 9 passes
`define PASS_W 4

`endif

// ==== hdl/dotEnginePkg.sv ====
`include "dotEngine_defs.svh"

package dotEnginePkg;

    // Addresses
    typedef logic [$clog2(`W_DEPTH)-1:0] wAddrT;
    typedef logic [$clog2(`P_DEPTH)-1:0] pAddrT;

    // Data
    typedef logic        [`PIX_W-1:0]  pixelT;
    typedef logic signed [`WGT_W-1:0]  weightT;
    typedef logic signed [`SUM_W-1:0]  sumT;
    typedef logic        [`PASS_W-1:0] passCntT;

    //////////////////////////////////////////////////
    // Beats and results
    //////////////////////////////////////////////////

    // Address generator to both stores
    typedef struct packed {
        wAddrT wAddr;
        pAddrT pAddr;
        logic  en;
        logic  first;
        logic  last;
    } addrBeatT;

    // Store outputs into the MAC unit
    typedef struct packed {
        weightT weight;
        pixelT  pixel;
        logic   en;
        logic   first;
        logic   last;
    } dataBeatT;

    typedef struct packed {
        sumT     sum;
        passCntT passIdx;
    } resultT;

    // State machines
    typedef enum logic [1:0] {agWait, agRun, agDone} agState;
    typedef enum logic [1:0] {seqIdle, seqRun, seqLast} seqState;

endpackage

// ==== hdl/addressGen.sv ====
`timescale 1ns/1ns
`include "dotEngine_defs.svh"

module addressGen
    import dotEnginePkg::*;
(
    input  logic     Clk,
    input  logic     rst,
    input  logic     runRequest,
    input  logic     moreRequest,
    output addrBeatT beat,
    output logic     passDone
);

    agState state;
    wAddrT  wAddr;
    pAddrT  pAddr;
    logic   lastBeat;

    // Final weight of the vector
    assign lastBeat = (wAddr == wAddrT'(`VEC_LEN - 1));

    //////////////////////////////////////////////////
    // State and address counters
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= agWait;
            wAddr <= '0;
            pAddr <= '0;
        end else begin
            case (state)
                agWait: begin
                    if (runRequest) begin
                        wAddr <= '0;
                        pAddr <= '0;
                        state <= agRun;
                    end
                end
                agRun: begin
                    // Pixel address keeps running into the next pass
                    wAddr <= wAddr + 1'b1;
                    pAddr <= pAddr + 1'b1;
                    if (lastBeat) begin
                        state <= agDone;
                    end
                end
                agDone: begin
                    if (runRequest) begin
                        wAddr <= '0;
                        pAddr <= '0;
                        state <= agRun;
                    end else if (moreRequest) begin
                        // Same weights, next block of pixels
                        wAddr <= '0;
                        state <= agRun;
                    end
                end
                default: begin
                    state <= agWait;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Beat outputs
    //////////////////////////////////////////////////

    always_comb begin
        beat.wAddr = wAddr;
        beat.pAddr = pAddr;
        beat.en    = (state == agRun);
        beat.first = (state == agRun) && (wAddr == '0);
        beat.last  = (state == agRun) && lastBeat;
    end

    assign passDone = (state == agDone);

endmodule

// ==== hdl/weightStore.sv ====
`timescale 1ns/1ns
`include "dotEngine_defs.svh"

module weightStore
    import dotEnginePkg::*;
(
    input  logic     Clk,
    input  logic     loadWeight,
    input  wAddrT    loadWAddr,
    input  weightT   loadWData,
    input  addrBeatT beat,
    output weightT   weight
);

    //////////////////////////////////////////////////
    // Weight memory
    //////////////////////////////////////////////////

    weightT mem [`W_DEPTH];

    // Host write port
    always_ff @(posedge Clk) begin
        if (loadWeight) begin
            mem[loadWAddr] <= loadWData;
        end
    end

    // Registered read, one cycle behind the beat
    always_ff @(posedge Clk) begin
        if (beat.en) begin
            weight <= mem[beat.wAddr];
        end
    end

endmodule

// ==== hdl/pixelStore.sv ====
`timescale 1ns/1ns
`include "dotEngine_defs.svh"

module pixelStore
    import dotEnginePkg::*;
(
    input  logic     Clk,
    input  logic     rst,
    input  logic     loadPixel,
    input  pAddrT    loadPAddr,
    input  pixelT    loadPData,
    input  addrBeatT beat,
    output pixelT    pixel,
    output logic     en,
    output logic     first,
    output logic     last
);

    //////////////////////////////////////////////////
    // Pixel buffer
    //////////////////////////////////////////////////

    pixelT mem [`P_DEPTH];

    always_ff @(posedge Clk) begin
        if (loadPixel) begin
            mem[loadPAddr] <= loadPData;
        end
    end

    always_ff @(posedge Clk) begin
        if (beat.en) begin
            pixel <= mem[beat.pAddr];
        end
    end

    // Flags follow the data through one stage
    always_ff @(posedge Clk) begin
        if (rst) begin
            en    <= 1'b0;
            first <= 1'b0;
            last  <= 1'b0;
        end else begin
            en    <= beat.en;
            first <= beat.first;
            last  <= beat.last;
        end
    end

endmodule

// ==== hdl/macUnit.sv ====
`timescale 1ns/1ns
`include "dotEngine_defs.svh"

module macUnit
    import dotEnginePkg::*;
(
    input  logic     Clk,
    input  logic     rst,
    input  logic     newRun,
    input  dataBeatT data,
    output logic     resultValid,
    output resultT   result
);

    logic signed [`PIX_W+`WGT_W:0] product;
    sumT                            acc;
    sumT                            nextSum;
    passCntT                        passIdx;

    //////////////////////////////////////////////////
    // Multiply and accumulate
    //////////////////////////////////////////////////

    // Pixel is unsigned, so zero-extend before the signed multiply
    assign product = data.weight * $signed({1'b0, data.pixel});

    // First beat reloads instead of adding
    assign nextSum = data.first ? sumT'(product) : acc + sumT'(product);

    always_ff @(posedge Clk) begin
        if (data.en) begin
            acc <= nextSum;
        end
    end

    // Result payload
    always_ff @(posedge Clk) begin
        if (data.en && data.last) begin
            result.sum     <= nextSum;
            result.passIdx <= passIdx;
        end
    end

    //////////////////////////////////////////////////
    // Result pulse and pass index
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            passIdx     <= '0;
        end else begin
            resultValid <= data.en && data.last;
            if (newRun) begin
                passIdx <= '0;
            end else if (data.en && data.last) begin
                passIdx <= passIdx + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/passSequencer.sv ====
`timescale 1ns/1ns

module passSequencer
    import dotEnginePkg::*;
(
    input  logic    Clk,
    input  logic    rst,
    input  logic    start,
    input  passCntT passCount,
    input  logic    passDone,
    input  logic    resultValid,
    output logic    runRequest,
    output logic    moreRequest,
    output logic    newRun,
    output logic    busy
);

    seqState state;
    passCntT passesLeft;
    passCntT resultsLeft;
    logic    doneSeen;

    // passDone is a level, ignore it while a request is still in flight
    assign doneSeen = passDone && !runRequest && !moreRequest;

    assign newRun = runRequest;

    //////////////////////////////////////////////////
    // Pass control
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            state       <= seqIdle;
            passesLeft  <= '0;
            resultsLeft <= '0;
            runRequest  <= 1'b0;
            moreRequest <= 1'b0;
            busy        <= 1'b0;
        end else begin
            runRequest  <= 1'b0;
            moreRequest <= 1'b0;

            // Results may land while passes are still being issued
            if (state != seqIdle && resultValid) begin
                resultsLeft <= resultsLeft - 1'b1;
            end

            case (state)
                seqIdle: begin
                    if (start) begin
                        runRequest  <= 1'b1;
                        busy        <= 1'b1;
                        passesLeft  <= passCount - 1'b1;
                        resultsLeft <= passCount;
                        state       <= (passCount == passCntT'(1)) ? seqLast : seqRun;
                    end
                end
                seqRun: begin
                    if (doneSeen) begin
                        moreRequest <= 1'b1;
                        passesLeft  <= passesLeft - 1'b1;
                        if (passesLeft == passCntT'(1)) begin
                            state <= seqLast;
                        end
                    end
                end
                seqLast: begin
                    // Wait for the final result
                    if (resultValid && resultsLeft == passCntT'(1)) begin
                        busy  <= 1'b0;
                        state <= seqIdle;
                    end
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

endmodule

// ==== hdl/dotEngineTop.sv ====
`timescale 1ns/1ns

module dotEngineTop
    import dotEnginePkg::*;
(
    input  logic    Clk,
    input  logic    rst,
    input  logic    loadWeight,
    input  wAddrT   loadWAddr,
    input  weightT  loadWData,
    input  logic    loadPixel,
    input  pAddrT   loadPAddr,
    input  pixelT   loadPData,
    input  logic    start,
    input  passCntT passCount,
    output logic    busy,
    output logic    resultValid,
    output resultT  result
);

    logic     runRequest;
    logic     moreRequest;
    logic     newRun;
    logic     passDone;
    addrBeatT addrBeat;
    weightT   storeWeight;
    pixelT    storePixel;
    logic     pixEn;
    logic     pixFirst;
    logic     pixLast;
    dataBeatT dataBeat;

    //////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////

    passSequencer seq_i (
        .Clk         (Clk),
        .rst         (rst),
        .start       (start),
        .passCount   (passCount),
        .passDone    (passDone),
        .resultValid (resultValid),
        .runRequest  (runRequest),
        .moreRequest (moreRequest),
        .newRun      (newRun),
        .busy        (busy)
    );

    addressGen agen_i (
        .Clk         (Clk),
        .rst         (rst),
        .runRequest  (runRequest),
        .moreRequest (moreRequest),
        .beat        (addrBeat),
        .passDone    (passDone)
    );

    //////////////////////////////////////////////////
    // Stores, read side by side
    //////////////////////////////////////////////////

    weightStore wstore_i (
        .Clk        (Clk),
        .loadWeight (loadWeight),
        .loadWAddr  (loadWAddr),
        .loadWData  (loadWData),
        .beat       (addrBeat),
        .weight     (storeWeight)
    );

    pixelStore pstore_i (
        .Clk       (Clk),
        .rst       (rst),
        .loadPixel (loadPixel),
        .loadPAddr (loadPAddr),
        .loadPData (loadPData),
        .beat      (addrBeat),
        .pixel     (storePixel),
        .en        (pixEn),
        .first     (pixFirst),
        .last      (pixLast)
    );

    // Both store outputs share one cycle of latency
    assign dataBeat = '{weight: storeWeight, pixel: storePixel, en: pixEn,
                        first: pixFirst, last: pixLast};

    macUnit mac_i (
        .Clk         (Clk),
        .rst         (rst),
        .newRun      (newRun),
        .data        (dataBeat),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

// ==== testbench/dotEngineChecker.sv ====
`timescale 1ns/1ns
`include "dotEngine_defs.svh"

module dotEngineChecker
    import dotEnginePkg::*;
(
    input logic   Clk,
    input logic   rst,
    input logic   start,
    input logic   busy,
    input logic   resultValid,
    input resultT result
);

    integer  expQ[$];
    integer  errorCount = 0;
    integer  resultCount = 0;
    passCntT expIdx = '0;
    logic    runSeen = 1'b0;
    sumT     expSum;
    sumT     gotSum;

    // Expected sums arrive from the stimulus driver in result order
    task automatic pushExpected(input integer value);
        expQ.push_back(value);
    endtask

    function automatic integer pendingCount();
        return expQ.size();
    endfunction

    //////////////////////////////////////////////////
    // Result monitor
    //////////////////////////////////////////////////

    always @(posedge Clk) begin
        if (!rst) begin
            if (start) begin
                runSeen <= 1'b1;
                expIdx  <= '0;
            end

            // Engine must stay quiet until the first start
            if (!runSeen && (busy || resultValid)) begin
                $display("Error: busy or resultValid went high before any start at %0t", $time);
                errorCount++;
            end

            if (resultValid) begin
                if (expQ.size() == 0) begin
                    $display("Error: a result arrived at %0t with no expected sum left", $time);
                    errorCount++;
                end else begin
                    expSum = sumT'(expQ.pop_front());
                    gotSum = result.sum;
                    if (gotSum != expSum) begin
                        $display("Mismatch at %0t: sum expected %0d, actual %0d",
                                 $time, expSum, gotSum);
                        errorCount++;
                    end
                    if (result.passIdx != expIdx) begin
                        $display("Mismatch at %0t: passIdx expected %0d, actual %0d",
                                 $time, expIdx, result.passIdx);
                        errorCount++;
                    end
                end
                expIdx      <= expIdx + 1'b1;
                resultCount <= resultCount + 1;
            end
        end
    end

endmodule

// ==== testbench/dotEngineTb.sv ====
`timescale 1ns/1ns
`include "dotEngine_defs.svh"

module dotEngineTb
    import dotEnginePkg::*;
;

    logic    Clk;
    logic    rst;
    logic    loadWeight;
    wAddrT   loadWAddr;
    weightT  loadWData;
    logic    loadPixel;
    pAddrT   loadPAddr;
    pixelT   loadPData;
    logic    start;
    passCntT passCount;
    logic    busy;
    logic    resultValid;
    resultT  result;

    integer loadCount = 0;
    integer passTotal = 0;
    integer driverErrors = 0;
    integer cycleCount = 0;
    integer cycleLimit = 200;

    dotEngineTop dut_i (
        .Clk         (Clk),
        .rst         (rst),
        .loadWeight  (loadWeight),
        .loadWAddr   (loadWAddr),
        .loadWData   (loadWData),
        .loadPixel   (loadPixel),
        .loadPAddr   (loadPAddr),
        .loadPData   (loadPData),
        .start       (start),
        .passCount   (passCount),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

    dotEngineChecker chk_i (
        .Clk         (Clk),
        .rst         (rst),
        .start       (start),
        .busy        (busy),
        .resultValid (resultValid),
        .result      (result)
    );

    initial Clk = 1'b0;
    always #20 Clk = ~Clk;

    // Run limit
    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Error: simulation timed out after %0d cycles", cycleCount);
            $display("Simulation FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Host side drivers
    //////////////////////////////////////////////////

    // Each driver starts and ends 2 ns after a rising edge
    task automatic writeWeight(input integer addr, input integer data);
        loadWeight = 1'b1;
        loadWAddr  = wAddrT'(addr);
        loadWData  = weightT'(data);
        @(posedge Clk);
        #2;
        loadWeight = 1'b0;
    endtask

    task automatic writePixel(input integer addr, input integer data);
        loadPixel = 1'b1;
        loadPAddr = pAddrT'(addr);
        loadPData = pixelT'(data);
        @(posedge Clk);
        #2;
        loadPixel = 1'b0;
    endtask

    task automatic runPasses(input integer count);
        integer resultsBefore;
        resultsBefore = chk_i.resultCount;
        start         = 1'b1;
        passCount     = passCntT'(count);
        @(posedge Clk);
        #2;
        start = 1'b0;
        while (busy) begin
            @(posedge Clk);
            #2;
        end
        if (chk_i.resultCount - resultsBefore != count) begin
            $display("Error: start with %0d passes gave %0d results",
                     count, chk_i.resultCount - resultsBefore);
            driverErrors++;
        end
        repeat (2) @(posedge Clk);
        #2;
        if (busy) begin
            $display("Error: busy rose again without a start at %0t", $time);
            driverErrors++;
        end
    endtask

    // Walks the stim file to count the work or to drive it
    task automatic parseStim(input bit execute);
        integer          fd;
        integer          code;
        integer          value;
        integer          addr;
        integer          i;
        reg [63:0]       tag;
        reg [8*256-1:0]  rest;
        fd = $fopen("testbench/dotEngine_stim.txt", "r");
        if (fd == 0) begin
            if (!execute) begin
                $display("Error: cannot open the stim file");
                driverErrors++;
            end
        end else begin
            code = $fscanf(fd, "%s", tag);
            while (code == 1) begin
                case (tag)
                    "//": begin
                        code = $fgets(rest, fd);
                    end
                    "W": begin
                        for (i = 0; i < `VEC_LEN; i++) begin
                            code = $fscanf(fd, "%h", value);
                            if (execute) writeWeight(i, value);
                            else loadCount++;
                        end
                    end
                    "P": begin
                        code = $fscanf(fd, "%h", addr);
                        for (i = 0; i < `VEC_LEN; i++) begin
                            code = $fscanf(fd, "%h", value);
                            if (execute) writePixel(addr + i, value);
                            else loadCount++;
                        end
                    end
                    "E": begin
                        code = $fscanf(fd, "%d", value);
                        if (execute) chk_i.pushExpected(value);
                    end
                    "R": begin
                        code = $fscanf(fd, "%d", value);
                        if (execute) runPasses(value);
                        else passTotal += value;
                    end
                    default: begin
                        if (!execute) begin
                            $display("Error: unknown tag in the stim file");
                            driverErrors++;
                        end
                    end
                endcase
                code = $fscanf(fd, "%s", tag);
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        rst        = 1'b1;
        loadWeight = 1'b0;
        loadWAddr  = '0;
        loadWData  = '0;
        loadPixel  = 1'b0;
        loadPAddr  = '0;
        loadPData  = '0;
        start      = 1'b0;
        passCount  = '0;

        parseStim(1'b0);
        cycleLimit = 4 * (loadCount + 40 * passTotal) + 200;

        repeat (5) @(posedge Clk);
        #2;
        rst = 1'b0;

        // Idle stretch while the checker watches busy and resultValid
        repeat (4) @(posedge Clk);
        #2;

        parseStim(1'b1);

        repeat (4) @(posedge Clk);
        #2;
        if (chk_i.pendingCount() != 0) begin
            $display("Error: %0d expected sums were never used", chk_i.pendingCount());
            driverErrors++;
        end

        $display("Errors: checker %0d, driver %0d", chk_i.errorCount, driverErrors);
        if (chk_i.errorCount + driverErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/dotEngine_stim.txt ====
// W = 28 weight bytes (hex), P = start address then 28 pixel bytes (hex)
// E = expected sum (decimal), given before the R = pass count line that produces it
W 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B 1C
P 00 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F 10 11 12 13 14 15 16 17 18 19 1A 1B
E 7308
R 1
P 1C 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A 0A
P 38 1B 1A 19 18 17 16 15 14 13 12 11 10 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00
E 7308
E 4060
E 3654
R 3
W 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 7F 7F
P 00 FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF FF
E -783870
E -30740
R 2

// ==== verilog.f ====
+incdir+hdl
hdl/dotEnginePkg.sv
hdl/addressGen.sv
hdl/weightStore.sv
hdl/pixelStore.sv
hdl/macUnit.sv
hdl/passSequencer.sv
hdl/dotEngineTop.sv
testbench/dotEngineChecker.sv
testbench/dotEngineTb.sv
